// ==== design/io_cfg.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pad I/O configuration
// Pad counts, field widths and pad register layout
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef IO_CFG_SVH
`define IO_CFG_SVH

// Pad bank and peripheral groups, pad k maps to bit k of every group
`define N_IO        16
`define N_PERIO     `N_IO
`define N_GPIO      `N_IO
`define N_FPGAIO    `N_IO

// Per-pad fields
`define NBIT_PADMUX 2
`define NBIT_PADCFG 4

// AXI4-Lite register port
`define AXI_ADDR_WIDTH 8
`define AXI_DATA_WIDTH 32

// Field positions inside each 32-bit pad register at offset 4*k
`define PADMUX_LSB  0
`define PADCFG_LSB  4

`endif

// ==== design/io_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pad I/O package
// Pad mux select and AXI response encodings
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "io_cfg.svh"

package io_pkg;

  // Which peripheral group owns a pad
  typedef enum logic [`NBIT_PADMUX-1:0] {
    PADMUX_OFF    = 2'd0,
    PADMUX_PERIO  = 2'd1,
    PADMUX_GPIO   = 2'd2,
    PADMUX_FPGAIO = 2'd3
  } pad_mux_e;

  // Subset of the AXI response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

// ==== design/pad_cfg_regs.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pad configuration registers
// AXI4-Lite slave holding one mux select and one pad config
// field per pad, one write and one read outstanding at most
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "io_cfg.svh"

module pad_cfg_regs import io_pkg::*; (
  input  logic                                ref_clk_i,
  input  logic                                arst_n_i,

  // Write address and data
  input  logic                                awvalid_i,
  input  logic [`AXI_ADDR_WIDTH-1:0]          awaddr_i,
  output logic                                awready_o,
  input  logic                                wvalid_i,
  input  logic [`AXI_DATA_WIDTH-1:0]          wdata_i,
  input  logic [`AXI_DATA_WIDTH/8-1:0]        wstrb_i,
  output logic                                wready_o,

  // Write response
  output logic                                bvalid_o,
  output axi_resp_e                           bresp_o,
  input  logic                                bready_i,

  // Read address
  input  logic                                arvalid_i,
  input  logic [`AXI_ADDR_WIDTH-1:0]          araddr_i,
  output logic                                arready_o,

  // Read data
  output logic                                rvalid_o,
  output logic [`AXI_DATA_WIDTH-1:0]          rdata_o,
  output axi_resp_e                           rresp_o,
  input  logic                                rready_i,

  // Register contents
  output pad_mux_e [`N_IO-1:0]                pad_mux_sel_o,
  output logic [`N_IO-1:0][`NBIT_PADCFG-1:0]  pad_cfg_o
);

  localparam int IDX_W = $clog2(`N_IO);
  localparam logic [`AXI_ADDR_WIDTH-1:0] REG_SPAN = `AXI_ADDR_WIDTH'(4 * `N_IO);

  pad_mux_e [`N_IO-1:0]               mux_q;
  logic [`N_IO-1:0][`NBIT_PADCFG-1:0] cfg_q;

  logic                               wr_hs;
  logic                               wr_ok;
  logic [IDX_W-1:0]                   wr_idx;
  logic                               bvalid_q;
  axi_resp_e                          bresp_q;

  logic                               rd_hs;
  logic                               rd_ok;
  logic [IDX_W-1:0]                   rd_idx;
  logic [`AXI_DATA_WIDTH-1:0]         rd_word;
  logic                               rvalid_q;
  axi_resp_e                          rresp_q;
  logic [`AXI_DATA_WIDTH-1:0]         rdata_q;

  // Address and data are taken together, only while no response is pending
  assign wr_hs     = awvalid_i & wvalid_i & ~bvalid_q;
  assign awready_o = wr_hs;
  assign wready_o  = wr_hs;

  assign wr_ok  = (awaddr_i[1:0] == 2'b00) && (awaddr_i < REG_SPAN);
  assign wr_idx = awaddr_i[2 +: IDX_W];

  always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int k = 0; k < `N_IO; k++) begin
        mux_q[k] <= PADMUX_OFF;
        cfg_q[k] <= '0;
      end
    end else if (wr_hs && wr_ok && wstrb_i[0]) begin
      mux_q[wr_idx] <= pad_mux_e'(wdata_i[`PADMUX_LSB +: `NBIT_PADMUX]);
      cfg_q[wr_idx] <= wdata_i[`PADCFG_LSB +: `NBIT_PADCFG];
    end
  end

  always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bvalid_q <= 1'b0;
    end else if (wr_hs) begin
      bvalid_q <= 1'b1;
    end else if (bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge ref_clk_i) begin
    if (wr_hs) begin
      bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // Read side
  assign arready_o = ~rvalid_q;
  assign rd_hs     = arvalid_i & ~rvalid_q;
  assign rd_ok     = (araddr_i[1:0] == 2'b00) && (araddr_i < REG_SPAN);
  assign rd_idx    = araddr_i[2 +: IDX_W];

  // Unused and out-of-range bits read as zero
  always_comb begin
    rd_word = '0;
    if (rd_ok) begin
      rd_word[`PADMUX_LSB +: `NBIT_PADMUX] = mux_q[rd_idx];
      rd_word[`PADCFG_LSB +: `NBIT_PADCFG] = cfg_q[rd_idx];
    end
  end

  always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_hs) begin
      rvalid_q <= 1'b1;
    end else if (rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge ref_clk_i) begin
    if (rd_hs) begin
      rdata_q <= rd_word;
      rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign bvalid_o      = bvalid_q;
  assign bresp_o       = bresp_q;
  assign rvalid_o      = rvalid_q;
  assign rdata_o       = rdata_q;
  assign rresp_o       = rresp_q;
  assign pad_mux_sel_o = mux_q;
  assign pad_cfg_o     = cfg_q;

  // A stalled response must stay put until the host takes it
  a_bvalid_hold : assert property (@(posedge ref_clk_i) disable iff (!arst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
    else $error("write response dropped before bready");

  a_rvalid_hold : assert property (@(posedge ref_clk_i) disable iff (!arst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
    else $error("read response dropped before rready");

endmodule

// ==== design/pad_in_sync.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pad input synchronizer
// Two flop stages per pad bit into the ref clock domain
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "io_cfg.svh"

module pad_in_sync (
  input  logic             ref_clk_i,
  input  logic             arst_n_i,
  input  logic [`N_IO-1:0] io_in_i,
  output logic [`N_IO-1:0] io_in_sync_o
);

  // First stage may go metastable, second one settles it
  logic [`N_IO-1:0] meta_q;
  logic [`N_IO-1:0] sync_q;

  always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= io_in_i;
      sync_q <= meta_q;
    end
  end

  assign io_in_sync_o = sync_q;

endmodule

// ==== design/pad_mux.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pad mux
// Routes the selected group's out/oe to each pad and the
// synchronized pad input back to that group only
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "io_cfg.svh"

module pad_mux import io_pkg::*; (
  input  pad_mux_e [`N_IO-1:0]   pad_mux_sel_i,
  input  logic [`N_IO-1:0]       io_in_sync_i,

  // Peripheral side
  input  logic [`N_PERIO-1:0]    perio_out_i,
  input  logic [`N_PERIO-1:0]    perio_oe_i,
  input  logic [`N_GPIO-1:0]     gpio_out_i,
  input  logic [`N_GPIO-1:0]     gpio_oe_i,
  input  logic [`N_FPGAIO-1:0]   fpgaio_out_i,
  input  logic [`N_FPGAIO-1:0]   fpgaio_oe_i,

  // Pad side
  output logic [`N_IO-1:0]       io_out_o,
  output logic [`N_IO-1:0]       io_oe_o,

  // Inputs returned to the peripherals
  output logic [`N_PERIO-1:0]    perio_in_o,
  output logic [`N_GPIO-1:0]     gpio_in_o,
  output logic [`N_FPGAIO-1:0]   fpgaio_in_o
);

  always_comb begin
    io_out_o    = '0;
    io_oe_o     = '0;
    perio_in_o  = '0;
    gpio_in_o   = '0;
    fpgaio_in_o = '0;
    for (int k = 0; k < `N_IO; k++) begin
      case (pad_mux_sel_i[k])
        PADMUX_PERIO: begin
          io_out_o[k]   = perio_out_i[k];
          io_oe_o[k]    = perio_oe_i[k];
          perio_in_o[k] = io_in_sync_i[k];
        end
        PADMUX_GPIO: begin
          io_out_o[k]  = gpio_out_i[k];
          io_oe_o[k]   = gpio_oe_i[k];
          gpio_in_o[k] = io_in_sync_i[k];
        end
        PADMUX_FPGAIO: begin
          io_out_o[k]    = fpgaio_out_i[k];
          io_oe_o[k]     = fpgaio_oe_i[k];
          fpgaio_in_o[k] = io_in_sync_i[k];
        end
        // Unowned pad is driven low with its output disabled
        default: ;
      endcase
    end
  end

  // No pad may feed two groups at once
  always_comb begin
    for (int k = 0; k < `N_IO; k++) begin
      a_one_owner : assert ($onehot0({perio_in_o[k], gpio_in_o[k], fpgaio_in_o[k]}))
        else $error("pad %0d input reaches more than one group", k);
    end
  end

endmodule

// ==== design/io_subsystem.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pad I/O subsystem
// Register file, input synchronizer and pad mux for a bank
// of pads shared by PERIO, GPIO and FPGAIO
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "io_cfg.svh"

module io_subsystem import io_pkg::*; (
  input  logic                                ref_clk_i,
  input  logic                                arst_n_i,

  // AXI4-Lite host port
  input  logic                                awvalid_i,
  input  logic [`AXI_ADDR_WIDTH-1:0]          awaddr_i,
  output logic                                awready_o,
  input  logic                                wvalid_i,
  input  logic [`AXI_DATA_WIDTH-1:0]          wdata_i,
  input  logic [`AXI_DATA_WIDTH/8-1:0]        wstrb_i,
  output logic                                wready_o,
  output logic                                bvalid_o,
  output axi_resp_e                           bresp_o,
  input  logic                                bready_i,
  input  logic                                arvalid_i,
  input  logic [`AXI_ADDR_WIDTH-1:0]          araddr_i,
  output logic                                arready_o,
  output logic                                rvalid_o,
  output logic [`AXI_DATA_WIDTH-1:0]          rdata_o,
  output axi_resp_e                           rresp_o,
  input  logic                                rready_i,

  // Pad frame
  input  logic [`N_IO-1:0]                    io_in_i,
  output logic [`N_IO-1:0]                    io_out_o,
  output logic [`N_IO-1:0]                    io_oe_o,
  output logic [`N_IO-1:0][`NBIT_PADCFG-1:0]  pad_cfg_o,

  // Peripheral groups
  input  logic [`N_PERIO-1:0]                 perio_out_i,
  input  logic [`N_PERIO-1:0]                 perio_oe_i,
  output logic [`N_PERIO-1:0]                 perio_in_o,
  input  logic [`N_GPIO-1:0]                  gpio_out_i,
  input  logic [`N_GPIO-1:0]                  gpio_oe_i,
  output logic [`N_GPIO-1:0]                  gpio_in_o,
  input  logic [`N_FPGAIO-1:0]                fpgaio_out_i,
  input  logic [`N_FPGAIO-1:0]                fpgaio_oe_i,
  output logic [`N_FPGAIO-1:0]                fpgaio_in_o
);

  pad_mux_e [`N_IO-1:0] pad_mux_sel;
  logic [`N_IO-1:0]     io_in_sync;

  pad_cfg_regs i_pad_cfg_regs (
    .ref_clk_i     (ref_clk_i),
    .arst_n_i      (arst_n_i),
    .awvalid_i     (awvalid_i),
    .awaddr_i      (awaddr_i),
    .awready_o     (awready_o),
    .wvalid_i      (wvalid_i),
    .wdata_i       (wdata_i),
    .wstrb_i       (wstrb_i),
    .wready_o      (wready_o),
    .bvalid_o      (bvalid_o),
    .bresp_o       (bresp_o),
    .bready_i      (bready_i),
    .arvalid_i     (arvalid_i),
    .araddr_i      (araddr_i),
    .arready_o     (arready_o),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o),
    .rresp_o       (rresp_o),
    .rready_i      (rready_i),
    .pad_mux_sel_o (pad_mux_sel),
    .pad_cfg_o     (pad_cfg_o)
  );

  pad_in_sync i_pad_in_sync (
    .ref_clk_i    (ref_clk_i),
    .arst_n_i     (arst_n_i),
    .io_in_i      (io_in_i),
    .io_in_sync_o (io_in_sync)
  );

  pad_mux i_pad_mux (
    .pad_mux_sel_i (pad_mux_sel),
    .io_in_sync_i  (io_in_sync),
    .perio_out_i   (perio_out_i),
    .perio_oe_i    (perio_oe_i),
    .gpio_out_i    (gpio_out_i),
    .gpio_oe_i     (gpio_oe_i),
    .fpgaio_out_i  (fpgaio_out_i),
    .fpgaio_oe_i   (fpgaio_oe_i),
    .io_out_o      (io_out_o),
    .io_oe_o       (io_oe_o),
    .perio_in_o    (perio_in_o),
    .gpio_in_o     (gpio_in_o),
    .fpgaio_in_o   (fpgaio_in_o)
  );

endmodule

// ==== bench/tb_model.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pad I/O testbench model
// LFSR stimulus source, shadow pad registers and the
// expected pad and peripheral routing
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef logic [`N_IO-1:0]           pads_t;
typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;

logic [31:0]                        lfsr_q = 32'hf391_5c04;
logic [`N_IO-1:0][`NBIT_PADMUX-1:0] model_mux = '0;
logic [`N_IO-1:0][`NBIT_PADCFG-1:0] model_cfg = '0;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  logic        fb;
  v = '0;
  for (int i = 0; i < n; i++) begin
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    v = {v[30:0], fb};
  end
  return v;
endfunction

function automatic logic addr_ok(input addr_t addr);
  return (addr[1:0] == 2'b00) && (addr < addr_t'(4 * `N_IO));
endfunction

function automatic void model_write(input addr_t addr, input logic [31:0] data,
                                    input logic [3:0] strb);
  if (addr_ok(addr) && strb[0]) begin
    model_mux[addr[2 +: $clog2(`N_IO)]] = data[`PADMUX_LSB +: `NBIT_PADMUX];
    model_cfg[addr[2 +: $clog2(`N_IO)]] = data[`PADCFG_LSB +: `NBIT_PADCFG];
  end
endfunction

// Unused bits and bad addresses read as zero
function automatic logic [31:0] exp_rdata(input addr_t addr);
  logic [31:0] w;
  w = '0;
  if (addr_ok(addr)) begin
    w[`PADMUX_LSB +: `NBIT_PADMUX] = model_mux[addr[2 +: $clog2(`N_IO)]];
    w[`PADCFG_LSB +: `NBIT_PADCFG] = model_cfg[addr[2 +: $clog2(`N_IO)]];
  end
  return w;
endfunction

function automatic pads_t route_out(input pads_t p, input pads_t g, input pads_t f);
  pads_t v;
  for (int k = 0; k < `N_IO; k++) begin
    case (model_mux[k])
      PADMUX_PERIO:  v[k] = p[k];
      PADMUX_GPIO:   v[k] = g[k];
      PADMUX_FPGAIO: v[k] = f[k];
      default:       v[k] = 1'b0;
    endcase
  end
  return v;
endfunction

function automatic pads_t route_in(input pad_mux_e grp, input pads_t pins);
  pads_t v;
  for (int k = 0; k < `N_IO; k++) begin
    v[k] = (model_mux[k] == grp) ? pins[k] : 1'b0;
  end
  return v;
endfunction

`endif

// ==== bench/tb_io_subsystem.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pad I/O subsystem testbench
// Random AXI4-Lite and pad traffic checked against a model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "io_cfg.svh"

module tb_io_subsystem import io_pkg::*; ();

  `include "tb_model.svh"

  localparam int CLK_PERIOD  = 8;
  localparam int N_ROUND     = 32;
  localparam int N_TXN       = 2 * `N_IO + 4 * N_ROUND;
  localparam int CYC_PER_TXN = 20;
  localparam int WATCHDOG_NS = (N_TXN * CYC_PER_TXN + 100) * CLK_PERIOD;

  logic                               ref_clk_i;
  logic                               arst_n_i;
  logic                               awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
  logic                               awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
  addr_t                              awaddr_i, araddr_i;
  logic [`AXI_DATA_WIDTH-1:0]         wdata_i, rdata_o;
  logic [`AXI_DATA_WIDTH/8-1:0]       wstrb_i;
  axi_resp_e                          bresp_o, rresp_o;
  pads_t                              io_in_i, io_out_o, io_oe_o;
  logic [`N_IO-1:0][`NBIT_PADCFG-1:0] pad_cfg_o;
  pads_t                              perio_out_i, perio_oe_i, perio_in_o;
  pads_t                              gpio_out_i, gpio_oe_i, gpio_in_o;
  pads_t                              fpgaio_out_i, fpgaio_oe_i, fpgaio_in_o;

  io_subsystem i_io_subsystem (.*);

  initial begin
    ref_clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) ref_clk_i = ~ref_clk_i;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
    $display("sim failed");
    $fatal(1);
  end

  task automatic check_eq(input string name, input logic [63:0] act, input logic [63:0] exp);
    assert (act === exp) else begin
      $display("FAIL %0t ns %s expected %0h got %0h", $time, name, exp, act);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // Odd rounds miss the word alignment, even rounds land past the last pad
  function automatic addr_t bad_addr(input logic unaligned);
    logic [1:0] lo;
    lo = 2'(rand_bits(2));
    if (lo == 2'b00) lo = 2'b01;
    if (unaligned) return addr_t'(4 * rand_bits($clog2(`N_IO))) | addr_t'(lo);
    else return addr_t'(4 * `N_IO + rand_bits(7));
  endfunction

  task automatic axi_write(input addr_t addr, input logic [31:0] data, input logic [3:0] strb);
    int        stall;
    axi_resp_e resp;
    stall = int'(rand_bits(3));
    resp  = addr_ok(addr) ? RESP_OKAY : RESP_SLVERR;
    @(negedge ref_clk_i);
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = strb;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    do @(negedge ref_clk_i); while (!bvalid_o);
    model_write(addr, data, strb);
    // Second write stays offered while the response is stalled
    wdata_i = rand_bits(32);
    for (int i = 0; i <= stall; i++) begin
      check_eq("bvalid_o", 64'(bvalid_o), 64'(1));
      check_eq("bresp_o", 64'(bresp_o), 64'(resp));
      check_eq("awready_o", 64'(awready_o), 64'(0));
      check_eq("wready_o", 64'(wready_o), 64'(0));
      if (i < stall) @(negedge ref_clk_i);
    end
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b1;
    @(negedge ref_clk_i);
    bready_i = 1'b0;
    check_eq("bvalid_o", 64'(bvalid_o), 64'(0));
    check_eq("pad_cfg_o", 64'(pad_cfg_o), 64'(model_cfg));
  endtask

  task automatic axi_read(input addr_t addr);
    int          stall;
    logic [31:0] exp_data;
    axi_resp_e   resp;
    stall    = int'(rand_bits(3));
    exp_data = exp_rdata(addr);
    resp     = addr_ok(addr) ? RESP_OKAY : RESP_SLVERR;
    @(negedge ref_clk_i);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    do @(negedge ref_clk_i); while (!rvalid_o);
    // Second read stays offered while the response is stalled
    araddr_i = addr_t'(rand_bits(`AXI_ADDR_WIDTH));
    for (int i = 0; i <= stall; i++) begin
      check_eq("rvalid_o", 64'(rvalid_o), 64'(1));
      check_eq("rdata_o", 64'(rdata_o), 64'(exp_data));
      check_eq("rresp_o", 64'(rresp_o), 64'(resp));
      check_eq("arready_o", 64'(arready_o), 64'(0));
      if (i < stall) @(negedge ref_clk_i);
    end
    arvalid_i = 1'b0;
    rready_i  = 1'b1;
    @(negedge ref_clk_i);
    rready_i = 1'b0;
    check_eq("rvalid_o", 64'(rvalid_o), 64'(0));
  endtask

  task automatic check_routing();
    @(negedge ref_clk_i);
    perio_out_i  = pads_t'(rand_bits(`N_IO));
    perio_oe_i   = pads_t'(rand_bits(`N_IO));
    gpio_out_i   = pads_t'(rand_bits(`N_IO));
    gpio_oe_i    = pads_t'(rand_bits(`N_IO));
    fpgaio_out_i = pads_t'(rand_bits(`N_IO));
    fpgaio_oe_i  = pads_t'(rand_bits(`N_IO));
    #(CLK_PERIOD / 4);
    check_eq("io_out_o", 64'(io_out_o), 64'(route_out(perio_out_i, gpio_out_i, fpgaio_out_i)));
    check_eq("io_oe_o", 64'(io_oe_o), 64'(route_out(perio_oe_i, gpio_oe_i, fpgaio_oe_i)));
    @(negedge ref_clk_i);
    io_in_i = pads_t'(rand_bits(`N_IO));
    repeat (3) @(negedge ref_clk_i);
    check_eq("perio_in_o", 64'(perio_in_o), 64'(route_in(PADMUX_PERIO, io_in_i)));
    check_eq("gpio_in_o", 64'(gpio_in_o), 64'(route_in(PADMUX_GPIO, io_in_i)));
    check_eq("fpgaio_in_o", 64'(fpgaio_in_o), 64'(route_in(PADMUX_FPGAIO, io_in_i)));
  endtask

  initial begin
    arst_n_i     = 1'b0;
    awvalid_i    = 1'b0;
    wvalid_i     = 1'b0;
    bready_i     = 1'b0;
    arvalid_i    = 1'b0;
    rready_i     = 1'b0;
    awaddr_i     = '0;
    araddr_i     = '0;
    wdata_i      = '0;
    wstrb_i      = '0;
    io_in_i      = '0;
    // Peripherals drive high so only unowned pads keep the outputs low
    perio_out_i  = '1;
    perio_oe_i   = '1;
    gpio_out_i   = '1;
    gpio_oe_i    = '1;
    fpgaio_out_i = '1;
    fpgaio_oe_i  = '1;
    repeat (4) @(negedge ref_clk_i);
    arst_n_i = 1'b1;
    @(negedge ref_clk_i);
    check_eq("io_out_o", 64'(io_out_o), 64'(0));
    check_eq("io_oe_o", 64'(io_oe_o), 64'(0));
    check_eq("pad_cfg_o", 64'(pad_cfg_o), 64'(0));
    check_eq("arready_o", 64'(arready_o), 64'(1));
    check_eq("bvalid_o", 64'(bvalid_o), 64'(0));
    check_eq("rvalid_o", 64'(rvalid_o), 64'(0));
    for (int k = 0; k < `N_IO; k++) axi_read(addr_t'(4 * k));
    check_routing();
    for (int r = 0; r < N_ROUND; r++) begin
      axi_write(addr_t'(4 * rand_bits($clog2(`N_IO))), rand_bits(32), 4'(rand_bits(4)));
      axi_read(addr_t'(4 * rand_bits($clog2(`N_IO))));
      axi_write(bad_addr(r[0]), rand_bits(32), 4'hf);
      axi_read(bad_addr(r[0]));
      check_routing();
    end
    for (int k = 0; k < `N_IO; k++) axi_read(addr_t'(4 * k));
    $display("sim passed");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+design
+incdir+bench
design/io_pkg.sv
design/pad_cfg_regs.sv
design/pad_in_sync.sv
design/pad_mux.sv
design/io_subsystem.sv
bench/tb_io_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pad I/O subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sources.f --top-module tb_io_subsystem -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build error"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
  exit 0
else
  echo "Pass message not found"
  exit 1
fi
